// File: sim.f
design/icache_line_pkg.sv
design/icache_geom_pkg.sv
design/cc_line_ram.sv
design/cc_tag_ram.sv
design/cc_way.sv
design/cc_fill_ctrl.sv
design/cc_clear_sweep.sv
design/icache_array.sv
verif/tb_clock.sv
verif/icache_tb.sv

// File: Bender.yml
package:
  name: icache_array

sources:
  # packages first, then the RTL in dependency order
  - design/icache_line_pkg.sv
  - design/icache_geom_pkg.sv
  - design/cc_line_ram.sv
  - design/cc_tag_ram.sv
  - design/cc_way.sv
  - design/cc_fill_ctrl.sv
  - design/cc_clear_sweep.sv
  - design/icache_array.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/icache_tb.sv

// File: verif/icache_tb.sv
// directed and random tests, reference model, read checker and watchdog
`timescale 1ns/1ps

module icache_tb;

  localparam int WAYS = icache_geom_pkg::DEF_WAYS;
  localparam int INDEX_BITS = icache_geom_pkg::DEF_INDEX_BITS;
  localparam int TAG_BITS = icache_geom_pkg::DEF_TAG_BITS;
  localparam int ADDR_BITS = INDEX_BITS + TAG_BITS;
  localparam int SETS = 1 << INDEX_BITS;
  localparam int PERIOD = 100;

  // per-test lengths in cycles
  localparam int LEN_RESET = 80;
  localparam int LEN_FILL = 8;
  localparam int LEN_PARTIAL = 14;
  localparam int LEN_EVICT = 20;
  localparam int LEN_INVAL = 80;
  localparam int LEN_RANDOM = 310;
  localparam int WATCH_CYCLES =
    2 * (LEN_RESET + LEN_FILL + LEN_PARTIAL + LEN_EVICT + LEN_INVAL + LEN_RANDOM);

  logic clk;
  logic rst;
  logic invalidate;
  logic rd_a_en;
  logic [ADDR_BITS-1:0] rd_a_addr;
  logic rd_a_hit;
  icache_line_pkg::line_t rd_a_data;
  logic rd_b_en;
  logic [ADDR_BITS-1:0] rd_b_addr;
  logic rd_b_hit;
  icache_line_pkg::line_t rd_b_data;
  logic fill_en;
  logic [ADDR_BITS-1:0] fill_addr;
  icache_line_pkg::line_t fill_data;
  icache_line_pkg::byte_en_t fill_ben;
  logic busy;

  // reference model state
  logic [TAG_BITS-1:0] m_tag [WAYS][SETS];
  logic m_valid [WAYS][SETS];
  icache_line_pkg::line_t m_line [WAYS][SETS];
  int m_victim [SETS];

  // fill and reads seen at the last edge
  logic fill_pend;
  logic [ADDR_BITS-1:0] fill_pend_addr;
  icache_line_pkg::line_t fill_pend_data;
  icache_line_pkg::byte_en_t fill_pend_ben;
  logic rd_a_pend;
  logic rd_b_pend;
  logic [ADDR_BITS-1:0] rd_a_held;
  logic [ADDR_BITS-1:0] rd_b_held;
  logic busy_seen;
  logic exp_hit;
  icache_line_pkg::line_t exp_data;

  logic [31:0] rng = 32'h1868_20e2;
  string cur_test = "init";
  int n_pass = 0;
  int n_fail = 0;
  int test_fail_base = 0;
  logic [ADDR_BITS-1:0] filled_q [$];

  tb_clock #(.PERIOD(PERIOD)) u_clk (.clk(clk));

  icache_array #(
    .WAYS      (WAYS),
    .INDEX_BITS(INDEX_BITS),
    .TAG_BITS  (TAG_BITS)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .invalidate(invalidate),
    .rd_a_en   (rd_a_en),
    .rd_a_addr (rd_a_addr),
    .rd_a_hit  (rd_a_hit),
    .rd_a_data (rd_a_data),
    .rd_b_en   (rd_b_en),
    .rd_b_addr (rd_b_addr),
    .rd_b_hit  (rd_b_hit),
    .rd_b_data (rd_b_data),
    .fill_en   (fill_en),
    .fill_addr (fill_addr),
    .fill_data (fill_data),
    .fill_ben  (fill_ben),
    .busy      (busy)
  );

  function automatic logic [31:0] next_rand();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  function automatic icache_line_pkg::line_t rand_line();
    icache_line_pkg::line_t l;
    for (int k = 0; k < icache_line_pkg::LINE_BITS / 32; k++) begin
      l.bits[k*32 +: 32] = next_rand();
    end
    return l;
  endfunction

  function automatic logic [ADDR_BITS-1:0] make_addr(input int tag, input int idx);
    return {TAG_BITS'(tag), INDEX_BITS'(idx)};
  endfunction

  // six tags over two sets force evictions
  function automatic logic [ADDR_BITS-1:0] pool_addr(input logic [31:0] r);
    return make_addr(32'h0a000 + (r[7:0] % 6), r[16] ? 5 : 9);
  endfunction

  function automatic logic model_read(input logic [ADDR_BITS-1:0] addr,
                                      output icache_line_pkg::line_t data);
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    logic hit;
    idx = addr[INDEX_BITS-1:0];
    tag = addr[ADDR_BITS-1:INDEX_BITS];
    hit = 1'b0;
    data = '0; // zero on a miss
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[w][idx] === 1'b1 && m_tag[w][idx] == tag) begin
        hit = 1'b1;
        data = m_line[w][idx];
      end
    end
    return hit;
  endfunction

  function automatic void model_fill(input logic [ADDR_BITS-1:0] addr,
                                     input icache_line_pkg::line_t data,
                                     input icache_line_pkg::byte_en_t ben);
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    int hit_way;
    int v;
    idx = addr[INDEX_BITS-1:0];
    tag = addr[ADDR_BITS-1:INDEX_BITS];
    hit_way = -1;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[w][idx] === 1'b1 && m_tag[w][idx] == tag) hit_way = w;
    end
    if (hit_way >= 0) begin
      for (int b = 0; b < icache_line_pkg::LINE_BYTES; b++) begin
        if (ben[b]) m_line[hit_way][idx].bytes[b] = data.bytes[b];
      end
    end else if (ben == '1) begin
      v = m_victim[idx]; // round-robin victim
      m_tag[v][idx] = tag;
      m_valid[v][idx] = 1'b1;
      m_line[v][idx] = data;
      m_victim[idx] = (v + 1) % WAYS;
    end
    // partial miss is dropped
  endfunction

  function automatic void model_clear();
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) m_valid[w][s] = 1'b0;
      m_victim[s] = 0;
    end
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  // model writes a fill one edge after its capture
  always @(posedge clk) begin
    if (rst) begin
      model_clear();
      fill_pend = 1'b0;
      rd_a_pend = 1'b0;
      rd_b_pend = 1'b0;
    end else begin
      if (fill_pend) model_fill(fill_pend_addr, fill_pend_data, fill_pend_ben);
      if (invalidate) model_clear();
      fill_pend = fill_en && !busy_seen && !invalidate;
      fill_pend_addr = fill_addr;
      fill_pend_data = fill_data;
      fill_pend_ben = fill_ben;
      rd_a_pend = rd_a_en;
      rd_b_pend = rd_b_en;
      if (rd_a_en) rd_a_held = rd_a_addr;
      if (rd_b_en) rd_b_held = rd_b_addr;
    end
  end

  // compare mid-cycle and skip reads while busy
  always @(negedge clk) begin
    busy_seen = busy;
    if (!rst && !busy) begin
      if (rd_a_pend) begin
        exp_hit = model_read(rd_a_held, exp_data);
        check_value({cur_test, " port A hit"}, 128'(exp_hit), 128'(rd_a_hit));
        check_value({cur_test, " port A data"}, exp_data.bits, rd_a_data.bits);
      end
      if (rd_b_pend) begin
        exp_hit = model_read(rd_b_held, exp_data);
        check_value({cur_test, " port B hit"}, 128'(exp_hit), 128'(rd_b_hit));
        check_value({cur_test, " port B data"}, exp_data.bits, rd_b_data.bits);
      end
    end
  end

  initial begin
    #(WATCH_CYCLES * PERIOD);
    $display("Error: watchdog expired after %0d cycles in test %s", WATCH_CYCLES, cur_test);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_fail_base = n_fail;
  endtask

  task automatic end_test();
    repeat (2) step(); // let the last checks land
    $display("test %-12s done, %0d failed checks", cur_test, n_fail - test_fail_base);
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (busy !== 1'b0 && n < limit) begin
      step();
      n++;
    end
    if (busy !== 1'b0) begin
      $display("Error: busy still high after %0d cycles in test %s", limit, cur_test);
      n_fail++;
    end
  endtask

  task automatic do_fill(input logic [ADDR_BITS-1:0] addr, input icache_line_pkg::line_t data,
                         input icache_line_pkg::byte_en_t ben);
    fill_en = 1'b1;
    fill_addr = addr;
    fill_data = data;
    fill_ben = ben;
    if (ben == '1) filled_q.push_back(addr);
    step();
    fill_en = 1'b0;
  endtask

  task automatic do_read(input logic [ADDR_BITS-1:0] addr_a, input logic [ADDR_BITS-1:0] addr_b);
    rd_a_en = 1'b1;
    rd_a_addr = addr_a;
    rd_b_en = 1'b1;
    rd_b_addr = addr_b;
    step();
    rd_a_en = 1'b0;
    rd_b_en = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [ADDR_BITS-1:0] addr0;
    logic [ADDR_BITS-1:0] absent;
    rst = 1'b1;
    invalidate = 1'b0;
    rd_a_en = 1'b0;
    rd_a_addr = '0;
    rd_b_en = 1'b0;
    rd_b_addr = '0;
    fill_en = 1'b0;
    fill_addr = '0;
    fill_data = '0;
    fill_ben = '0;
    busy_seen = 1'b1;
    addr0 = make_addr(32'h12345, 3);
    absent = make_addr(32'h0beef, 7);

    begin_test("reset_sweep");
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    check_value("reset_sweep busy", 128'd1, 128'(busy));
    wait_idle(SETS + 6);
    do_read('0, addr0);
    do_read(absent, make_addr(32'hfffff, SETS - 1));
    end_test();

    begin_test("full_fill");
    do_fill(addr0, rand_line(), '1);
    do_read(addr0, addr0);
    end_test();

    begin_test("partial_fill");
    do_fill(addr0, rand_line(), 16'h00f0);
    do_fill(addr0, rand_line(), 16'h8001); // back to back on one line
    do_read(addr0, addr0);
    do_fill(absent, rand_line(), 16'h0f0f);
    do_read(absent, addr0);
    end_test();

    begin_test("eviction");
    for (int k = 0; k <= WAYS; k++) do_fill(make_addr(32'h40000 + k, 12), rand_line(), '1);
    for (int k = 0; k <= WAYS; k++) begin
      do_read(make_addr(32'h40000 + k, 12), make_addr(32'h40000 + WAYS - k, 12));
    end
    end_test();

    begin_test("invalidate");
    invalidate = 1'b1;
    step();
    invalidate = 1'b0;
    check_value("invalidate busy", 128'd1, 128'(busy));
    wait_idle(SETS + 6);
    for (int i = 0; i < filled_q.size(); i++) begin
      do_read(filled_q[i], filled_q[filled_q.size() - 1 - i]);
    end
    end_test();

    begin_test("random");
    for (int i = 0; i < 300; i++) begin
      r = next_rand();
      fill_en = r[0] | r[1];
      fill_addr = pool_addr(next_rand());
      fill_data = rand_line();
      fill_ben = r[2] ? '1 : icache_line_pkg::byte_en_t'(next_rand());
      rd_a_en = r[3];
      rd_a_addr = pool_addr(next_rand());
      rd_b_en = r[4];
      rd_b_addr = pool_addr(next_rand());
      step();
    end
    fill_en = 1'b0;
    rd_a_en = 1'b0;
    rd_b_en = 1'b0;
    end_test();

    $display("checks: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verif/tb_clock.sv
// free-running testbench clock source
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule

// File: design/icache_array.sv
// top level with way chain, fill controller and clear sweep
`timescale 1ns/1ps

module icache_array #(
  parameter int WAYS       = icache_geom_pkg::DEF_WAYS,
  parameter int INDEX_BITS = icache_geom_pkg::DEF_INDEX_BITS,
  parameter int TAG_BITS   = icache_geom_pkg::DEF_TAG_BITS
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           invalidate,
  input  logic                           rd_a_en,
  input  logic [INDEX_BITS+TAG_BITS-1:0] rd_a_addr,
  output logic                           rd_a_hit,
  output icache_line_pkg::line_t         rd_a_data,
  input  logic                           rd_b_en,
  input  logic [INDEX_BITS+TAG_BITS-1:0] rd_b_addr,
  output logic                           rd_b_hit,
  output icache_line_pkg::line_t         rd_b_data,
  input  logic                           fill_en,
  input  logic [INDEX_BITS+TAG_BITS-1:0] fill_addr,
  input  icache_line_pkg::line_t         fill_data,
  input  icache_line_pkg::byte_en_t      fill_ben,
  output logic                           busy
);

  wire icache_line_pkg::line_t chain_a [WAYS+1];
  wire icache_line_pkg::line_t chain_b [WAYS+1];
  wire [WAYS-1:0] hit_a;
  wire [WAYS-1:0] hit_b;
  wire [WAYS-1:0] fill_hit_way;
  wire [WAYS-1:0] wr_way;

  logic clear_en;
  logic [INDEX_BITS-1:0] clear_idx;
  logic [INDEX_BITS-1:0] fill_index;
  logic [TAG_BITS-1:0] fill_tag;
  icache_line_pkg::line_t wr_data;
  icache_line_pkg::byte_en_t wr_ben;

  cc_clear_sweep #(.INDEX_BITS(INDEX_BITS)) u_sweep (
    .clk       (clk),
    .rst       (rst),
    .invalidate(invalidate),
    .busy      (busy),
    .clear_en  (clear_en),
    .clear_idx (clear_idx)
  );

  cc_fill_ctrl #(
    .WAYS      (WAYS),
    .INDEX_BITS(INDEX_BITS),
    .TAG_BITS  (TAG_BITS)
  ) u_fill (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .fill_en     (fill_en),
    .fill_addr   (fill_addr),
    .fill_data   (fill_data),
    .fill_ben    (fill_ben),
    .fill_index  (fill_index),
    .fill_tag    (fill_tag),
    .fill_hit_way(fill_hit_way),
    .wr_way      (wr_way),
    .wr_data     (wr_data),
    .wr_ben      (wr_ben),
    .clear_en    (clear_en),
    .clear_idx   (clear_idx)
  );

  assign chain_a[0] = '0; // chain head
  assign chain_b[0] = '0;

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    cc_way #(
      .INDEX_BITS(INDEX_BITS),
      .TAG_BITS  (TAG_BITS)
    ) u_way (
      .clk         (clk),
      .rst         (rst),
      .rd_a_en     (rd_a_en),
      .rd_a_addr   (rd_a_addr),
      .rd_a_data_in(chain_a[w]),
      .rd_a_data   (chain_a[w+1]),
      .rd_a_hit    (hit_a[w]),
      .rd_b_en     (rd_b_en),
      .rd_b_addr   (rd_b_addr),
      .rd_b_data_in(chain_b[w]),
      .rd_b_data   (chain_b[w+1]),
      .rd_b_hit    (hit_b[w]),
      .fill_index  (fill_index),
      .fill_tag    (fill_tag),
      .fill_hit    (fill_hit_way[w]),
      .wr_en       (wr_way[w]),
      .wr_data     (wr_data),
      .wr_ben      (wr_ben),
      .clear_en    (clear_en),
      .clear_idx   (clear_idx)
    );
  end

  assign rd_a_data = chain_a[WAYS]; // last link
  assign rd_b_data = chain_b[WAYS];
  assign rd_a_hit = |hit_a;
  assign rd_b_hit = |hit_b;

endmodule

// File: design/cc_clear_sweep.sv
// set index walk after reset or invalidate, with the busy flag
`timescale 1ns/1ps

module cc_clear_sweep #(
  parameter int INDEX_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  invalidate,
  output logic                  busy,
  output logic                  clear_en,
  output logic [INDEX_BITS-1:0] clear_idx
);

  logic running;

  always_ff @(posedge clk) begin
    if (rst || invalidate) begin
      running <= 1'b1; // restart from set 0
      clear_idx <= '0;
    end else if (running) begin
      if (clear_idx == '1) running <= 1'b0;
      else clear_idx <= clear_idx + 1'b1;
    end
  end

  assign busy = running;
  assign clear_en = running;

endmodule

// File: design/cc_fill_ctrl.sv
// fill capture register, target way select and round-robin victim pointers
`timescale 1ns/1ps

module cc_fill_ctrl #(
  parameter int WAYS,
  parameter int INDEX_BITS,
  parameter int TAG_BITS
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           busy,
  input  logic                           fill_en,
  input  logic [INDEX_BITS+TAG_BITS-1:0] fill_addr,
  input  icache_line_pkg::line_t         fill_data,
  input  icache_line_pkg::byte_en_t      fill_ben,
  output logic [INDEX_BITS-1:0]          fill_index,
  output logic [TAG_BITS-1:0]            fill_tag,
  input  logic [WAYS-1:0]                fill_hit_way,
  output logic [WAYS-1:0]                wr_way,
  output icache_line_pkg::line_t         wr_data,
  output icache_line_pkg::byte_en_t      wr_ben,
  input  logic                           clear_en,
  input  logic [INDEX_BITS-1:0]          clear_idx
);

  localparam int ADDR_BITS = INDEX_BITS + TAG_BITS;
  localparam int SETS = 1 << INDEX_BITS;
  localparam int PTR_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  logic req_q;
  logic [ADDR_BITS-1:0] addr_q;
  icache_line_pkg::line_t data_q;
  icache_line_pkg::byte_en_t ben_q;

  logic [PTR_BITS-1:0] victim [SETS];
  logic [PTR_BITS-1:0] victim_cur;
  logic full_line;
  logic any_hit;
  logic alloc;

  always_ff @(posedge clk) begin
    if (rst) req_q <= 1'b0;
    else req_q <= fill_en & ~busy & (|fill_ben); // dropped while sweeping
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      addr_q <= fill_addr;
      data_q <= fill_data;
      ben_q <= fill_ben;
    end
  end

  assign fill_index = addr_q[INDEX_BITS-1:0];
  assign fill_tag = addr_q[ADDR_BITS-1:INDEX_BITS];
  assign wr_data = data_q;
  assign wr_ben = ben_q;

  assign victim_cur = victim[fill_index];
  assign full_line = &ben_q;
  assign any_hit = |fill_hit_way;
  assign alloc = req_q & ~clear_en & ~any_hit & full_line;

  // hit way first, else victim on a full line, else nothing
  always_comb begin
    wr_way = '0;
    if (req_q && !clear_en) begin
      if (any_hit) wr_way = fill_hit_way;
      else if (full_line) wr_way[victim_cur] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (clear_en) begin
      victim[clear_idx] <= '0;
    end else if (alloc) begin
      victim[fill_index] <= (victim_cur == PTR_BITS'(WAYS - 1)) ? '0 : victim_cur + 1'b1;
    end
  end

  // a tag never lives in two ways of one set
  a_wr_way_onehot: assert property (
    @(posedge clk) disable iff (rst) $onehot0(wr_way)
  );

endmodule

// File: design/cc_way.sv
// one cache way with its tag and line RAMs and its link of the read chain
`timescale 1ns/1ps

module cc_way #(
  parameter int INDEX_BITS,
  parameter int TAG_BITS
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           rd_a_en,
  input  logic [INDEX_BITS+TAG_BITS-1:0] rd_a_addr,
  input  icache_line_pkg::line_t         rd_a_data_in,
  output icache_line_pkg::line_t         rd_a_data,
  output logic                           rd_a_hit,
  input  logic                           rd_b_en,
  input  logic [INDEX_BITS+TAG_BITS-1:0] rd_b_addr,
  input  icache_line_pkg::line_t         rd_b_data_in,
  output icache_line_pkg::line_t         rd_b_data,
  output logic                           rd_b_hit,
  input  logic [INDEX_BITS-1:0]          fill_index,
  input  logic [TAG_BITS-1:0]            fill_tag,
  output logic                           fill_hit,
  input  logic                           wr_en,
  input  icache_line_pkg::line_t         wr_data,
  input  icache_line_pkg::byte_en_t      wr_ben,
  input  logic                           clear_en,
  input  logic [INDEX_BITS-1:0]          clear_idx
);

  localparam int ADDR_BITS = INDEX_BITS + TAG_BITS;

  icache_line_pkg::line_t line_a;
  icache_line_pkg::line_t line_b;
  logic tag_wr;

  assign tag_wr = wr_en & ~fill_hit; // tag written on allocation only

  cc_tag_ram #(
    .INDEX_BITS(INDEX_BITS),
    .TAG_BITS  (TAG_BITS)
  ) u_tag (
    .clk       (clk),
    .rst       (rst),
    .rd_a_en   (rd_a_en),
    .rd_a_index(rd_a_addr[INDEX_BITS-1:0]),
    .rd_a_tag  (rd_a_addr[ADDR_BITS-1:INDEX_BITS]),
    .rd_a_hit  (rd_a_hit),
    .rd_b_en   (rd_b_en),
    .rd_b_index(rd_b_addr[INDEX_BITS-1:0]),
    .rd_b_tag  (rd_b_addr[ADDR_BITS-1:INDEX_BITS]),
    .rd_b_hit  (rd_b_hit),
    .fill_index(fill_index),
    .fill_tag  (fill_tag),
    .fill_hit  (fill_hit),
    .wr_en     (tag_wr),
    .wr_index  (fill_index),
    .wr_tag    (fill_tag),
    .clear_en  (clear_en),
    .clear_idx (clear_idx)
  );

  cc_line_ram #(
    .INDEX_BITS(INDEX_BITS)
  ) u_line (
    .clk       (clk),
    .rst       (rst),
    .rd_a_en   (rd_a_en),
    .rd_a_index(rd_a_addr[INDEX_BITS-1:0]),
    .rd_a_line (line_a),
    .rd_b_en   (rd_b_en),
    .rd_b_index(rd_b_addr[INDEX_BITS-1:0]),
    .rd_b_line (line_b),
    .wr_en     (wr_en),
    .wr_index  (fill_index),
    .wr_data   (wr_data),
    .wr_ben    (wr_ben)
  );

  // gate by hit, merge into the chain from the previous way
  always_comb begin
    rd_a_data.bits = rd_a_data_in.bits |
                     ({icache_line_pkg::LINE_BITS{rd_a_hit}} & line_a.bits);
    rd_b_data.bits = rd_b_data_in.bits |
                     ({icache_line_pkg::LINE_BITS{rd_b_hit}} & line_b.bits);
  end

endmodule

// File: design/cc_tag_ram.sv
// per-way tag and valid arrays with two read compares, a fill compare and a clear
`timescale 1ns/1ps

module cc_tag_ram #(
  parameter int INDEX_BITS,
  parameter int TAG_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_a_en,
  input  logic [INDEX_BITS-1:0] rd_a_index,
  input  logic [TAG_BITS-1:0]   rd_a_tag,
  output logic                  rd_a_hit,
  input  logic                  rd_b_en,
  input  logic [INDEX_BITS-1:0] rd_b_index,
  input  logic [TAG_BITS-1:0]   rd_b_tag,
  output logic                  rd_b_hit,
  input  logic [INDEX_BITS-1:0] fill_index,
  input  logic [TAG_BITS-1:0]   fill_tag,
  output logic                  fill_hit,
  input  logic                  wr_en,
  input  logic [INDEX_BITS-1:0] wr_index,
  input  logic [TAG_BITS-1:0]   wr_tag,
  input  logic                  clear_en,
  input  logic [INDEX_BITS-1:0] clear_idx
);

  localparam int SETS = 1 << INDEX_BITS;

  logic [TAG_BITS-1:0] tags [SETS];
  logic [SETS-1:0] valid;

  logic [INDEX_BITS-1:0] rd_a_index_q;
  logic [TAG_BITS-1:0] rd_a_tag_q;
  logic [INDEX_BITS-1:0] rd_b_index_q;
  logic [TAG_BITS-1:0] rd_b_tag_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_a_index_q <= '0;
      rd_a_tag_q <= '0;
      rd_b_index_q <= '0;
      rd_b_tag_q <= '0;
    end else begin
      if (rd_a_en) begin
        rd_a_index_q <= rd_a_index;
        rd_a_tag_q <= rd_a_tag;
      end
      if (rd_b_en) begin
        rd_b_index_q <= rd_b_index;
        rd_b_tag_q <= rd_b_tag;
      end
    end
  end

  // sweep has priority over a write
  always_ff @(posedge clk) begin
    if (clear_en) valid[clear_idx] <= 1'b0;
    else if (wr_en) valid[wr_index] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (wr_en) tags[wr_index] <= wr_tag;
  end

  // compares run on the live arrays, so later fills show up
  assign rd_a_hit = valid[rd_a_index_q] && (tags[rd_a_index_q] == rd_a_tag_q);
  assign rd_b_hit = valid[rd_b_index_q] && (tags[rd_b_index_q] == rd_b_tag_q);
  assign fill_hit = valid[fill_index] && (tags[fill_index] == fill_tag); // captured fill

  // fill stage holds off its write select while the sweep runs
  a_no_wr_during_clear: assert property (
    @(posedge clk) disable iff (rst) !(wr_en && clear_en)
  );

endmodule

// File: design/cc_line_ram.sv
// per-way line storage with byte-masked write and two held-address reads
`timescale 1ns/1ps

module cc_line_ram #(
  parameter int INDEX_BITS
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_a_en,
  input  logic [INDEX_BITS-1:0]  rd_a_index,
  output icache_line_pkg::line_t rd_a_line,
  input  logic                   rd_b_en,
  input  logic [INDEX_BITS-1:0]  rd_b_index,
  output icache_line_pkg::line_t rd_b_line,
  input  logic                   wr_en,
  input  logic [INDEX_BITS-1:0]  wr_index,
  input  icache_line_pkg::line_t wr_data,
  input  icache_line_pkg::byte_en_t wr_ben
);

  localparam int SETS = 1 << INDEX_BITS;

  icache_line_pkg::line_t mem [SETS];
  logic [INDEX_BITS-1:0] rd_a_index_q;
  logic [INDEX_BITS-1:0] rd_b_index_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_a_index_q <= '0;
      rd_b_index_q <= '0;
    end else begin
      if (rd_a_en) rd_a_index_q <= rd_a_index; // held until next read
      if (rd_b_en) rd_b_index_q <= rd_b_index;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < icache_line_pkg::LINE_BYTES; b++) begin
        if (wr_ben[b]) mem[wr_index].bytes[b] <= wr_data.bytes[b];
      end
    end
  end

  assign rd_a_line = mem[rd_a_index_q];
  assign rd_b_line = mem[rd_b_index_q];

  // the fill stage never selects a way for an empty byte mask
  a_wr_ben_nonzero: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> (wr_ben != '0)
  );

endmodule

// File: design/icache_geom_pkg.sv
// default cache geometry with way count, set index width and tag width
package icache_geom_pkg;

  localparam int DEF_WAYS = 4;

  // 64 sets
  localparam int DEF_INDEX_BITS = 6;

  // line address is tag above index
  localparam int DEF_TAG_BITS = 20;

endpackage

// File: design/icache_line_pkg.sv
// byte and line widths, byte enable type and the line word union
package icache_line_pkg;

  localparam int LINE_BYTES = 16;
  localparam int BYTE_BITS = 8;
  localparam int LINE_BITS = LINE_BYTES * BYTE_BITS;

  // one enable per byte lane of a line
  typedef logic [LINE_BYTES-1:0] byte_en_t;

  // flat view for storage and the way chain, byte view for masked writes
  typedef union packed {
    logic [LINE_BITS-1:0] bits;
    logic [LINE_BYTES-1:0][BYTE_BITS-1:0] bytes;
  } line_t;

endpackage
